/* test/irCases.txt */
// Columns are cache word, AD word, carry, magic7/8 and mode, all in hex
// Mode holds mbXfer, enIoJrst and enAc from the high bit down
0ac0 000000000 0 0 1
0ac5 800000000 1 2 1
0ac3 400000000 0 1 0
1ca7 010000000 1 3 2
1fca 008000000 0 2 3
1fc5 004000000 1 0 1
1fff 561000000 1 3 5
0000 e53800123 0 1 6
0000 002000000 1 1 0
1234 000000001 0 2 3
0ac0 001000000 1 2 3
1ff0 020000000 0 3 3
0f0f fffffffff 1 1 1
1e01 000000000 1 3 2
0ac1 7ffffffff 0 2 0
1555 5a5a5a5a5 1 0 7
0aca 100000000 0 1 1
1dbf 000800000 0 0 3
0001 200000000 1 2 1
1fff 0000003f0 0 3 3

/* list.f */
hw/irPkg.sv
hw/irRegister.sv
hw/dispatchRam.sv
hw/adCondition.sv
hw/diagReadMux.sv
hw/irBoard.sv
test/irBoardTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = irBoardTb
FILELIST = list.f
MDIR = obj_dir
LOG = sim.log
PASS = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: compile
	./$(MDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)

/* test/irBoardTb.sv */
`timescale 1ns/1ps
`default_nettype none

module irBoardTb import irPkg::*; ();

  localparam int maxCases = 64;
  localparam int wordsPerCase = 5;

  logic CON;
  logic rstN;
  logic loadIr;
  logic mbXfer;
  irWord cacheData;
  adWord ad;
  logic adCarry;
  logic [7:8] magic;
  logic loadDram;
  logic dramWe;
  dramAddr dramWrAddr;
  dramEntry dramWrData;
  logic diagLoad;
  logic diagRead;
  diagFunc diagSel;
  logic diagData0;

  irWord ir;
  acWord ac;
  logic jrst0;
  fieldA dramA;
  fieldB dramB;
  fieldJ dramJ;
  logic testSatisfied;
  logic adZero;
  normCode norm;
  logic parityOk;
  logic ebusDrive;
  ebusByte ebusData;

  // Five hex words per case, unread slots stay all ones
  logic [35:0] caseWords [0:wordsPerCase*maxCases-1];
  dramEntry ramModel [0:dramEntries-1];
  int numCases = 0;
  int errors = 0;
  int cycles = 0;
  int cycleLimit = 600;
  int seed = 32'hdae6_c5f1;

  irBoard uut (
    .CON(CON), .rstN(rstN), .loadIr(loadIr), .mbXfer(mbXfer), .cacheData(cacheData),
    .ad(ad), .adCarry(adCarry), .magic(magic), .loadDram(loadDram), .dramWe(dramWe),
    .dramWrAddr(dramWrAddr), .dramWrData(dramWrData), .diagLoad(diagLoad),
    .diagRead(diagRead), .diagSel(diagSel), .diagData0(diagData0), .ir(ir), .ac(ac),
    .jrst0(jrst0), .dramA(dramA), .dramB(dramB), .dramJ(dramJ),
    .testSatisfied(testSatisfied), .adZero(adZero), .norm(norm), .parityOk(parityOk),
    .ebusDrive(ebusDrive), .ebusData(ebusData)
  );

  initial begin
    CON = 1'b0;
    forever #2 CON = ~CON;
  end

  always @(posedge CON) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("timeout after %0d cycles", cycles);
      $display("tests failed");
      $finish;
    end
  end

  task automatic reportBad(input string name, input logic [35:0] got,
                           input logic [35:0] exp);
    errors++;
    $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
  endtask

  // Position of the leading one picks the shift group
  function automatic normCode normOf(input adWord v);
    int first;
    first = -1;
    for (int k = 35; k >= 0; k--)
      if (v[k])
        first = k;
    if (first < 0)
      return 3'd0;
    else if (first == 0)
      return 3'd1;
    else if (first <= 6)
      return 3'd2;
    else if (first >= 11)
      return 3'd7;
    else
      return normCode'(first - 4);
  endfunction

  function automatic logic testOf(input adWord v, input logic carry,
                                  input logic [7:8] mg, input fieldB b);
    logic raw;
    raw = 1'b0;
    if (b[1] && v == 36'h0)
      raw = 1'b1;
    if (b[2] && mg[7] && (v[0] != carry))
      raw = 1'b1;
    if (b[2] && mg[8] && v[0])
      raw = 1'b1;
    if (carry && (mg[7] == mg[8]))
      raw = 1'b1;
    return b[0] ? !raw : raw;
  endfunction

  task automatic runCase(input int idx);
    irWord cache;
    adWord adVal;
    logic carry;
    logic [7:8] mg;
    logic [2:0] mode;
    irWord expIr;
    acWord expAc;
    dramAddr addr;
    dramEntry e;
    logic isJrst;
    logic expJrst0;
    logic expTest;
    fieldJ expJ;
    normCode expNorm;
    ebusByte expBus;
    diagFunc sel;
    cache = caseWords[wordsPerCase*idx][12:0];
    adVal = caseWords[wordsPerCase*idx+1];
    carry = caseWords[wordsPerCase*idx+2][0];
    mg = caseWords[wordsPerCase*idx+3][1:0];
    mode = caseWords[wordsPerCase*idx+4][2:0];
    sel = diagFunc'(idx % 8);

    // Mode bits first, then the IR, then the dispatch
    @(posedge CON);
    cacheData <= cache;
    ad <= adVal;
    adCarry <= carry;
    magic <= mg;
    mbXfer <= mode[2];
    diagLoad <= 1'b1;
    diagSel <= diagLoadIoJrst;
    diagData0 <= mode[1];
    @(posedge CON);
    diagSel <= diagLoadAc;
    diagData0 <= mode[0];
    @(posedge CON);
    diagLoad <= 1'b0;
    loadIr <= 1'b1;
    @(posedge CON);
    loadIr <= 1'b0;
    loadDram <= 1'b1;
    @(posedge CON);
    loadDram <= 1'b0;
    diagRead <= 1'b1;
    diagSel <= sel;

    expIr = mode[2] ? adVal[0:12] : cache;
    expAc = mode[0] ? expIr[9:12] : 4'h0;
    isJrst = (expIr[0:8] == 9'o254);
    expJrst0 = isJrst && (expIr[9:12] == 4'h0);
    if (mode[1] && expIr[0:2] == 3'b111) begin
      addr[0:2] = 3'b111;
      addr[3:5] = (expIr[3:6] == 4'hf) ? 3'b111 : expIr[7:9];
      addr[6:8] = expIr[10:12];
    end else begin
      addr = expIr[0:8];
    end
    e = ramModel[addr];
    expJ = isJrst ? e[6:9] : expIr[9:12];
    expTest = testOf(adVal, carry, mg, e[3:5]);
    expNorm = normOf(adVal);
    case (sel)
      3'd0: expBus = {expNorm, addr[0:2]};
      3'd1: expBus = addr[3:8];
      3'd2: expBus = {mode[1], mode[0], expAc};
      3'd3: expBus = {e[0:2], e[3:5]};
      3'd4: expBus = {expTest, expJrst0, expJ};
      3'd5: expBus = {^e, &expIr[3:6], (expIr[9:12] == 4'h0), (adVal == 36'h0), mg};
      3'd6: expBus = adVal[0:5];
      default: expBus = adVal[30:35];
    endcase

    @(negedge CON);
    if (ir !== expIr)
      reportBad("ir", 36'(ir), 36'(expIr));
    if (ac !== expAc)
      reportBad("ac", 36'(ac), 36'(expAc));
    if (jrst0 !== expJrst0)
      reportBad("jrst0", 36'(jrst0), 36'(expJrst0));
    if (dramA !== e[0:2])
      reportBad("dramA", 36'(dramA), 36'(e[0:2]));
    if (dramB !== e[3:5])
      reportBad("dramB", 36'(dramB), 36'(e[3:5]));
    if (dramJ !== expJ)
      reportBad("dramJ", 36'(dramJ), 36'(expJ));
    if (parityOk !== ^e)
      reportBad("parityOk", 36'(parityOk), 36'(^e));
    if (adZero !== (adVal == 36'h0))
      reportBad("adZero", 36'(adZero), 36'(adVal == 36'h0));
    if (testSatisfied !== expTest)
      reportBad("testSatisfied", 36'(testSatisfied), 36'(expTest));
    if (norm !== expNorm)
      reportBad("norm", 36'(norm), 36'(expNorm));
    if (ebusDrive !== 1'b1)
      reportBad("ebusDrive", 36'(ebusDrive), 36'h1);
    if (ebusData !== expBus)
      reportBad("ebusData", 36'(ebusData), 36'(expBus));

    // Released bus reads zero
    @(posedge CON);
    diagRead <= 1'b0;
    @(negedge CON);
    if (ebusDrive !== 1'b0)
      reportBad("ebusDrive", 36'(ebusDrive), 36'h0);
    if (ebusData !== 6'h0)
      reportBad("ebusData", 36'(ebusData), 36'h0);
  endtask

  initial begin
    dramEntry word;
    logic [31:0] r;
    rstN <= 1'b0;
    loadIr <= 1'b0;
    mbXfer <= 1'b0;
    cacheData <= '0;
    ad <= '0;
    adCarry <= 1'b0;
    magic <= 2'b00;
    loadDram <= 1'b0;
    dramWe <= 1'b0;
    dramWrAddr <= '0;
    dramWrData <= '0;
    diagLoad <= 1'b0;
    diagRead <= 1'b0;
    diagSel <= '0;
    diagData0 <= 1'b0;

    for (int k = 0; k < wordsPerCase * maxCases; k++)
      caseWords[k] = '1;
    $readmemh("test/irCases.txt", caseWords);
    while (numCases < maxCases && caseWords[wordsPerCase*numCases] <= 36'h1fff)
      numCases++;
    if (numCases == 0) begin
      $display("no cases found in test/irCases.txt");
      errors++;
    end
    cycleLimit = numCases * 8 + 600;

    repeat (2) @(posedge CON);
    rstN <= 1'b1;
    @(negedge CON);
    if (ir !== '0)
      reportBad("ir", 36'(ir), 36'h0);
    if (ac !== '0)
      reportBad("ac", 36'(ac), 36'h0);
    if (dramA !== '0)
      reportBad("dramA", 36'(dramA), 36'h0);
    if (ebusDrive !== 1'b0)
      reportBad("ebusDrive", 36'(ebusDrive), 36'h0);

    // Odd parity entries, every 16th one spoiled
    for (int a = 0; a < dramEntries; a++) begin
      r = $random(seed);
      word[0:9] = r[9:0];
      word[10] = ~^r[9:0];
      if (a % 16 == 0)
        word[10] = ~word[10];
      ramModel[a] = word;
      @(posedge CON);
      dramWe <= 1'b1;
      dramWrAddr <= dramAddr'(a);
      dramWrData <= word;
    end
    @(posedge CON);
    dramWe <= 1'b0;

    for (int i = 0; i < numCases; i++)
      runCase(i);

    $display("%0d errors in %0d cases", errors, numCases);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/irBoard.sv */
`timescale 1ns/1ps
`default_nettype none

module irBoard import irPkg::*; (
  input  logic       CON,
  input  logic       rstN,
  input  logic       loadIr,
  input  logic       mbXfer,
  input  irWord      cacheData,
  input  adWord      ad,
  input  logic       adCarry,
  input  logic [7:8] magic,
  input  logic       loadDram,
  input  logic       dramWe,
  input  dramAddr    dramWrAddr,
  input  dramEntry   dramWrData,
  input  logic       diagLoad,
  input  logic       diagRead,
  input  diagFunc    diagSel,
  input  logic       diagData0,
  output irWord      ir,
  output acWord      ac,
  output logic       jrst0,
  output fieldA      dramA,
  output fieldB      dramB,
  output fieldJ      dramJ,
  output logic       testSatisfied,
  output logic       adZero,
  output normCode    norm,
  output logic       parityOk,
  output logic       ebusDrive,
  output ebusByte    ebusData
);

  logic enIoJrst;
  logic enAc;
  logic jrst;
  logic ioLegal;
  logic acEq0;
  dramAddr dradr;

  irRegister irReg (
    .CON(CON), .rstN(rstN), .loadIr(loadIr), .mbXfer(mbXfer),
    .cacheData(cacheData), .ad(ad), .diagLoad(diagLoad), .diagSel(diagSel),
    .diagData0(diagData0), .ir(ir), .ac(ac), .enIoJrst(enIoJrst), .enAc(enAc),
    .jrst(jrst), .jrst0(jrst0), .ioLegal(ioLegal), .acEq0(acEq0)
  );

  // Parity bit itself is only observed through parityOk
  dispatchRam dram (
    .CON(CON), .rstN(rstN), .loadDram(loadDram), .ir(ir), .enIoJrst(enIoJrst),
    .jrst(jrst), .dramWe(dramWe), .dramWrAddr(dramWrAddr), .dramWrData(dramWrData),
    .dradr(dradr), .dramA(dramA), .dramB(dramB), .dramJ(dramJ), .dramPar(),
    .parityOk(parityOk)
  );

  adCondition cond (
    .ad(ad), .adCarry(adCarry), .magic(magic), .dramB(dramB),
    .adZero(adZero), .testSatisfied(testSatisfied), .norm(norm)
  );

  diagReadMux diagMux (
    .diagRead(diagRead), .diagSel(diagSel), .norm(norm), .dradr(dradr),
    .enIoJrst(enIoJrst), .enAc(enAc), .ac(ac), .dramA(dramA), .dramB(dramB),
    .dramJ(dramJ), .testSatisfied(testSatisfied), .jrst0(jrst0), .parityOk(parityOk),
    .ioLegal(ioLegal), .acEq0(acEq0), .adZero(adZero), .magic(magic), .ad(ad),
    .ebusDrive(ebusDrive), .ebusData(ebusData)
  );

endmodule

`default_nettype wire

/* hw/diagReadMux.sv */
`timescale 1ns/1ps
`default_nettype none

module diagReadMux import irPkg::*; (
  input  logic       diagRead,
  input  diagFunc    diagSel,
  input  normCode    norm,
  input  dramAddr    dradr,
  input  logic       enIoJrst,
  input  logic       enAc,
  input  acWord      ac,
  input  fieldA      dramA,
  input  fieldB      dramB,
  input  fieldJ      dramJ,
  input  logic       testSatisfied,
  input  logic       jrst0,
  input  logic       parityOk,
  input  logic       ioLegal,
  input  logic       acEq0,
  input  logic       adZero,
  input  logic [7:8] magic,
  input  adWord      ad,
  output logic       ebusDrive,
  output ebusByte    ebusData
);

  assign ebusDrive = diagRead;

  // Bus reads zero when the board is not driving
  always_comb begin
    ebusData = '0;
    if (diagRead) begin
      case (diagSel)
        3'd0: ebusData = {norm, dradr[0:2]};
        3'd1: ebusData = dradr[3:8];
        3'd2: ebusData = {enIoJrst, enAc, ac};
        3'd3: ebusData = {dramA, dramB};
        3'd4: ebusData = {testSatisfied, jrst0, dramJ};
        3'd5: ebusData = {parityOk, ioLegal, acEq0, adZero, magic[7], magic[8]};
        3'd6: ebusData = ad[0:5];
        default: ebusData = ad[30:35];
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/adCondition.sv */
`timescale 1ns/1ps
`default_nettype none

module adCondition import irPkg::*; (
  input  adWord      ad,
  input  logic       adCarry,
  input  logic [7:8] magic,
  input  fieldB      dramB,
  output logic       adZero,
  output logic       testSatisfied,
  output normCode    norm
);

  logic aGtB;
  logic magicEq;
  logic rawTest;

  assign adZero = ~|ad;
  assign aGtB = ad[0] ^ adCarry;
  assign magicEq = (magic[7] == magic[8]);

  // EQ, GT, LT and carry terms
  assign rawTest = (dramB[1] & adZero)
                 | (dramB[2] & magic[7] & aGtB)
                 | (dramB[2] & magic[8] & ad[0])
                 | (adCarry & magicEq);

  assign testSatisfied = rawTest ^ dramB[0];

  // Normalize priority, highest bit first
  always_comb begin
    if (ad[0])
      norm = 3'd1;
    else if (|ad[1:6])
      norm = 3'd2;
    else if (ad[7])
      norm = 3'd3;
    else if (ad[8])
      norm = 3'd4;
    else if (ad[9])
      norm = 3'd5;
    else if (ad[10])
      norm = 3'd6;
    else if (|ad[11:35])
      norm = 3'd7;
    else
      norm = 3'd0;
  end

endmodule

`default_nettype wire

/* hw/dispatchRam.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatchRam import irPkg::*; (
  input  logic     CON,
  input  logic     rstN,
  input  logic     loadDram,
  input  irWord    ir,
  input  logic     enIoJrst,
  input  logic     jrst,
  input  logic     dramWe,
  input  dramAddr  dramWrAddr,
  input  dramEntry dramWrData,
  output dramAddr  dradr,
  output fieldA    dramA,
  output fieldB    dramB,
  output fieldJ    dramJ,
  output logic     dramPar,
  output logic     parityOk
);

  dramEntry mem [0:dramEntries-1];
  dramEntry entry;
  dramAddr addrNext;
  fieldJ storedJ;
  logic instr7xx;
  logic instr3to6;

  // I/O class is opcode 7xx when the remap is enabled
  assign instr7xx = (&ir[0:2]) & enIoJrst;
  assign instr3to6 = &ir[3:6];

  always_comb begin
    if (instr7xx)
      addrNext = {3'b111, ir[7:9] | {3{instr3to6}}, ir[10:12]};
    else
      addrNext = ir[0:8];
  end

  // Diagnostic write port
  always_ff @(posedge CON) begin
    if (dramWe)
      mem[dramWrAddr] <= dramWrData;
  end

  assign entry = mem[addrNext];

  always_ff @(posedge CON or negedge rstN) begin
    if (!rstN) begin
      dradr <= '0;
      dramA <= '0;
      dramB <= '0;
      storedJ <= '0;
      dramJ <= '0;
      dramPar <= 1'b0;
    end else if (loadDram) begin
      dradr <= addrNext;
      dramA <= entry[0:2];
      dramB <= entry[3:5];
      storedJ <= entry[6:9];
      dramPar <= entry[10];
      // JRST dispatches on J, everything else on AC
      dramJ <= jrst ? entry[6:9] : ir[9:12];
    end
  end

  // Entry is stored with odd parity
  assign parityOk = ^{dramA, dramB, storedJ, dramPar};

  // A diagnostic write must not collide with a dispatch read
  noWriteReadCollision: assert property (
    @(posedge CON) disable iff (!rstN)
    !(dramWe && loadDram && (dramWrAddr == addrNext))
  );

endmodule

`default_nettype wire

/* hw/irRegister.sv */
`timescale 1ns/1ps
`default_nettype none

module irRegister import irPkg::*; (
  input  logic    CON,
  input  logic    rstN,
  input  logic    loadIr,
  input  logic    mbXfer,
  input  irWord   cacheData,
  input  adWord   ad,
  input  logic    diagLoad,
  input  diagFunc diagSel,
  input  logic    diagData0,
  output irWord   ir,
  output acWord   ac,
  output logic    enIoJrst,
  output logic    enAc,
  output logic    jrst,
  output logic    jrst0,
  output logic    ioLegal,
  output logic    acEq0
);

  irWord irNext;

  // AD path is used during MB transfers, cache otherwise
  assign irNext = mbXfer ? ad[0:irWidth-1] : cacheData;

  always_ff @(posedge CON or negedge rstN) begin
    if (!rstN) begin
      ir <= '0;
      ac <= '0;
    end else if (loadIr) begin
      ir <= irNext;
      ac <= enAc ? irNext[9:12] : '0;
    end
  end

  // Mode bits loaded by diagnostic function
  always_ff @(posedge CON or negedge rstN) begin
    if (!rstN) begin
      enIoJrst <= 1'b0;
      enAc <= 1'b0;
    end else if (diagLoad) begin
      if (diagSel == diagLoadIoJrst)
        enIoJrst <= diagData0;
      if (diagSel == diagLoadAc)
        enAc <= diagData0;
    end
  end

  assign jrst = (ir[0:8] == opJrst);
  assign acEq0 = (ir[9:12] == '0);
  assign jrst0 = jrst & acEq0;
  assign ioLegal = &ir[3:6];

endmodule

`default_nettype wire

/* hw/irPkg.sv */
`default_nettype none

package irPkg;

  // Instruction field latched from AD or cache, bit 0 is the MSB
  localparam int irWidth = 13;
  localparam int acWidth = 4;

  // Arithmetic bus, bit 0 is the sign
  localparam int adWidth = 36;

  // Dispatch RAM geometry
  localparam int dramAddrBits = 9;
  localparam int dramEntries = 1 << dramAddrBits;
  localparam int dramEntryWidth = 11;

  typedef logic [0:irWidth-1] irWord;
  typedef logic [0:acWidth-1] acWord;
  typedef logic [0:adWidth-1] adWord;
  typedef logic [0:dramAddrBits-1] dramAddr;

  // B field: bit 0 inverts, bit 1 enables EQ, bit 2 enables GT/LT
  typedef logic [0:2] fieldA;
  typedef logic [0:2] fieldB;
  typedef logic [0:3] fieldJ;

  // Entry layout is A, B, J, then the parity bit
  typedef logic [0:dramEntryWidth-1] dramEntry;

  typedef logic [2:0] normCode;
  typedef logic [0:5] ebusByte;
  typedef logic [2:0] diagFunc;

  localparam logic [0:8] opJrst = 9'o254;

  // Diagnostic load functions for the mode enables
  localparam diagFunc diagLoadIoJrst = 3'd5;
  localparam diagFunc diagLoadAc = 3'd6;

endpackage

`default_nettype wire
